// File: logic/rv_alu.sv
/* rv32i integer alu, ten operations */
`timescale 1ns/10ps

module rv_alu (
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    input  rv_pkg::alu_op_t op,
    output rv_pkg::word_t   result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            rv_pkg::alu_add:  result = a + b;
            rv_pkg::alu_sub:  result = a - b;
            rv_pkg::alu_sll:  result = a << shamt;
            rv_pkg::alu_slt:  result = {{(rv_pkg::xlen-1){1'b0}}, lt_signed};
            rv_pkg::alu_sltu: result = {{(rv_pkg::xlen-1){1'b0}}, lt_unsigned};
            rv_pkg::alu_xor:  result = a ^ b;
            rv_pkg::alu_srl:  result = a >> shamt;
            rv_pkg::alu_sra:  result = $signed(a) >>> shamt;  // keeps sign
            rv_pkg::alu_or:   result = a | b;
            rv_pkg::alu_and:  result = a & b;
            default:          result = '0;
        endcase
    end

endmodule

// File: logic/rv_core.sv
/* multi-cycle rv32i core top, one instruction in flight, fetch via request / response strobes */
`timescale 1ns/10ps

module rv_core #(
    parameter rv_pkg::word_t reset_pc = 32'h8000_0000
) (
    input  logic            clk,
    input  logic            reset,
    output logic            fetch_valid,
    output rv_pkg::word_t   fetch_addr,
    input  logic            inst_valid,
    input  rv_pkg::word_t   inst_data,
    output logic            retire_valid,
    output rv_pkg::retire_t retire
);

    rv_pkg::word_t    inst;
    rv_pkg::word_t    pc;
    rv_pkg::decoded_t dec;
    rv_pkg::word_t    rdata1;
    rv_pkg::word_t    rdata2;
    rv_pkg::word_t    jump_target;
    logic             jump_en;
    logic             rf_we;

    rv_fetch #(
        .reset_pc (reset_pc)
    ) u_fetch (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst_data    (inst_data),
        .jump_en      (jump_en),
        .jump_target  (jump_target),
        .fetch_valid  (fetch_valid),
        .fetch_addr   (fetch_addr),
        .inst         (inst),
        .pc           (pc),
        .retire_valid (retire_valid)
    );

    rv_decoder u_decoder (
        .inst (inst),
        .dec  (dec)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .we     (rf_we),
        .waddr  (dec.rd),
        .wdata  (retire.wdata),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    rv_execute u_execute (
        .dec          (dec),
        .pc           (pc),
        .rdata1       (rdata1),
        .rdata2       (rdata2),
        .retire_valid (retire_valid),
        .jump_en      (jump_en),
        .jump_target  (jump_target),
        .rf_we        (rf_we),
        .retire       (retire)
    );

endmodule

// File: logic/rv_decoder.sv
/* rv32i decoder: field split, instruction class, immediate build and alu op select */
`timescale 1ns/10ps

module rv_decoder (
    input  rv_pkg::word_t    inst,
    output rv_pkg::decoded_t dec
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic                alt;      // funct7 bit 5, sub / sra
    rv_pkg::inst_class_t inst_class;
    rv_pkg::word_t       imm;
    rv_pkg::alu_op_t     alu_op;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign alt    = inst[30];

    always_comb begin
        case (opcode)
            rv_pkg::op_reg:    inst_class = rv_pkg::class_r;
            rv_pkg::op_imm:    inst_class = rv_pkg::class_i;
            rv_pkg::op_lui,
            rv_pkg::op_auipc:  inst_class = rv_pkg::class_u;
            rv_pkg::op_branch: inst_class = rv_pkg::class_b;
            rv_pkg::op_jal:    inst_class = rv_pkg::class_j;
            rv_pkg::op_jalr:   inst_class = rv_pkg::class_jalr;
            default:           inst_class = rv_pkg::class_illegal;
        endcase
    end

    always_comb begin
        case (inst_class)
            rv_pkg::class_i,
            rv_pkg::class_jalr: imm = {{20{inst[31]}}, inst[31:20]};
            rv_pkg::class_u:    imm = {inst[31:12], 12'b0};
            rv_pkg::class_b:    imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            rv_pkg::class_j:    imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:            imm = '0;  // r type and illegal
        endcase
    end

    // everything outside reg / imm arithmetic adds
    always_comb begin
        alu_op = rv_pkg::alu_add;
        if (inst_class == rv_pkg::class_r || inst_class == rv_pkg::class_i) begin
            case (funct3)
                3'b000: begin
                    if (inst_class == rv_pkg::class_r && alt) alu_op = rv_pkg::alu_sub;
                end
                3'b001:  alu_op = rv_pkg::alu_sll;
                3'b010:  alu_op = rv_pkg::alu_slt;
                3'b011:  alu_op = rv_pkg::alu_sltu;
                3'b100:  alu_op = rv_pkg::alu_xor;
                3'b101:  alu_op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
                3'b110:  alu_op = rv_pkg::alu_or;
                default: alu_op = rv_pkg::alu_and;
            endcase
        end
    end

    always_comb begin
        dec.inst_class = inst_class;
        dec.opcode     = opcode;
        dec.funct3     = funct3;
        dec.rd         = inst[11:7];
        dec.rs1        = inst[19:15];
        dec.rs2        = inst[24:20];
        dec.imm        = imm;
        dec.alu_op     = alu_op;
    end

endmodule

// File: logic/rv_execute.sv
/* execute step: alu operand select, branch decision, jump target and write-back value */
`timescale 1ns/10ps

module rv_execute (
    input  rv_pkg::decoded_t dec,
    input  rv_pkg::word_t    pc,
    input  rv_pkg::word_t    rdata1,
    input  rv_pkg::word_t    rdata2,
    input  logic             retire_valid,
    output logic             jump_en,
    output rv_pkg::word_t    jump_target,
    output logic             rf_we,
    output rv_pkg::retire_t  retire
);

    rv_pkg::word_t alu_a;
    rv_pkg::word_t alu_b;
    rv_pkg::word_t alu_result;
    rv_pkg::word_t link;
    logic          take;
    logic          we;

    rv_alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (dec.alu_op),
        .result (alu_result)
    );

    assign link = pc + 32'd4;

    always_comb begin
        alu_a = pc;  // jal, branch, auipc
        alu_b = dec.imm;
        case (dec.inst_class)
            rv_pkg::class_r: begin
                alu_a = rdata1;
                alu_b = rdata2;
            end
            rv_pkg::class_i,
            rv_pkg::class_jalr: alu_a = rdata1;
            rv_pkg::class_u: begin
                if (dec.opcode == rv_pkg::op_lui) alu_a = '0;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            3'b000:  take = (rdata1 == rdata2);
            3'b001:  take = (rdata1 != rdata2);
            3'b100:  take = ($signed(rdata1) < $signed(rdata2));
            3'b101:  take = ($signed(rdata1) >= $signed(rdata2));
            3'b110:  take = (rdata1 < rdata2);
            3'b111:  take = (rdata1 >= rdata2);
            default: take = 1'b0;
        endcase
    end

    assign jump_en = (dec.inst_class == rv_pkg::class_j) ||
                     (dec.inst_class == rv_pkg::class_jalr) ||
                     (dec.inst_class == rv_pkg::class_b && take);
    assign jump_target = (dec.inst_class == rv_pkg::class_jalr) ?
                         {alu_result[rv_pkg::xlen-1:1], 1'b0} : alu_result;

    // branches and illegal opcodes write nothing
    assign we    = (dec.inst_class != rv_pkg::class_b) &&
                   (dec.inst_class != rv_pkg::class_illegal);
    assign rf_we = we & retire_valid;

    always_comb begin
        retire.pc      = pc;
        retire.rd      = dec.rd;
        retire.we      = we;
        retire.illegal = (dec.inst_class == rv_pkg::class_illegal);
        if (dec.inst_class == rv_pkg::class_j || dec.inst_class == rv_pkg::class_jalr)
            retire.wdata = link;
        else
            retire.wdata = alu_result;
    end

endmodule

// File: logic/rv_fetch.sv
/* fetch sequencer: holds the pc, issues fetch strobes and latches the returned
   instruction for the one-at-a-time execute step */
`timescale 1ns/10ps

module rv_fetch #(
    parameter rv_pkg::word_t reset_pc = 32'h8000_0000
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          inst_valid,
    input  rv_pkg::word_t inst_data,
    input  logic          jump_en,
    input  rv_pkg::word_t jump_target,
    output logic          fetch_valid,
    output rv_pkg::word_t fetch_addr,
    output rv_pkg::word_t inst,
    output rv_pkg::word_t pc,
    output logic          retire_valid
);

    typedef enum logic [1:0] {
        st_start,
        st_wait,
        st_exec
    } state_t;

    state_t        state;
    logic          boot_req;   // first request after reset
    rv_pkg::word_t next_pc;
    rv_pkg::word_t inst_q;

    assign next_pc      = jump_en ? jump_target : pc + 32'd4;
    assign retire_valid = (state == st_exec);
    assign fetch_valid  = boot_req | (state == st_exec);
    assign fetch_addr   = (state == st_exec) ? next_pc : pc;
    assign inst         = inst_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= st_start;
            boot_req <= 1'b0;
            pc       <= reset_pc;
        end else begin
            boot_req <= (state == st_start);
            case (state)
                st_start: state <= st_wait;
                st_wait:  if (inst_valid) state <= st_exec;
                st_exec: begin
                    state <= st_wait;  // next fetch goes out this cycle
                    pc    <= next_pc;
                end
                default:  state <= st_start;
            endcase
        end
    end

    // latched instruction word
    always_ff @(posedge clk) begin
        if (inst_valid) inst_q <= inst_data;
    end

    // memory answers only an outstanding request
    a_resp_in_wait: assert property (@(posedge clk) disable iff (reset)
        inst_valid |-> state == st_wait);

endmodule

// File: logic/rv_pkg.sv
/* rv32i core shared definitions
   widths, opcodes, instruction classes, alu operations and the decode / retire structs */
package rv_pkg;

    parameter int xlen       = 32;
    parameter int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    // major opcodes still handled by the core
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;

    typedef enum logic [2:0] {
        class_r,
        class_i,
        class_u,        // lui and auipc
        class_b,
        class_j,
        class_jalr,
        class_illegal
    } inst_class_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    typedef struct packed {
        inst_class_t inst_class;
        logic [6:0]  opcode;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        word_t       imm;
        alu_op_t     alu_op;
    } decoded_t;

    // one completed instruction
    typedef struct packed {
        word_t    pc;
        reg_idx_t rd;
        word_t    wdata;
        logic     we;
        logic     illegal;  // unsupported opcode, nothing written
    } retire_t;

endpackage

// File: logic/rv_regfile.sv
/* integer register file, 31 writable entries with x0 reading as zero */
`timescale 1ns/10ps

module rv_regfile (
    input  logic             clk,
    input  logic             reset,
    input  logic             we,
    input  rv_pkg::reg_idx_t waddr,
    input  rv_pkg::word_t    wdata,
    input  rv_pkg::reg_idx_t raddr1,
    input  rv_pkg::reg_idx_t raddr2,
    output rv_pkg::word_t    rdata1,
    output rv_pkg::word_t    rdata2
);

    rv_pkg::word_t regs [1:31];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin  // x0 writes dropped
            regs[waddr] <= wdata;
        end
    end

    // combinational read ports
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // write index comes from the decoded instruction
    a_waddr_known: assert property (@(posedge clk) disable iff (reset)
        we |-> !$isunknown(waddr));

endmodule

// File: project.f
logic/rv_pkg.sv
logic/rv_alu.sv
logic/rv_fetch.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_execute.sv
logic/rv_core.sv
tb/clock_gen.sv
tb/tb_core.sv

// File: run.sh
#!/bin/sh
# verilator build and run of the rv32i core testbench
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb_core \
    -f project.f > build.log 2>&1 &&
./obj_dir/Vtb_core > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || exit 0

// File: tb/clock_gen.sv
/* testbench clock and reset source, 8 ns clock, reset held 2 cycles per restart request */
`timescale 1ns/10ps

module clock_gen (
    input  logic restart,
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset is high from time zero until the first request ends
    initial begin
        reset = 1'b1;
        forever begin
            @(posedge restart);
            reset = 1'b1;
            repeat (2) @(posedge clk);
            #1;
            reset = 1'b0;  // released with the other stimulus
        end
    end

endmodule

// File: tb/tb_core.sv
/* testbench for the multi-cycle rv32i core: instruction memory with random latency,
   shadow reference model and directed program tests */
`timescale 1ns/10ps

module tb_core;

    localparam rv_pkg::word_t reset_pc = 32'h8000_0000;
    localparam int mem_words   = 64;
    localparam int max_insts   = 100;  // bound on instructions over all tests
    localparam int watchdog_ns = max_insts * 5 * 8 + 1000;

    logic            clk;
    logic            reset;
    logic            restart;
    logic            inst_valid;
    rv_pkg::word_t   inst_data;
    logic            fetch_valid;
    rv_pkg::word_t   fetch_addr;
    logic            retire_valid;
    rv_pkg::retire_t retire;

    rv_pkg::word_t mem [mem_words];
    rv_pkg::word_t prog_q [$];
    rv_pkg::word_t ref_regs [32];   // shadow register file
    rv_pkg::word_t ref_pc;
    integer        seed;
    int            errors;

    clock_gen u_clock_gen (
        .restart (restart),
        .clk     (clk),
        .reset   (reset)
    );

    rv_core #(
        .reset_pc (reset_pc)
    ) uut (
        .clk          (clk),
        .reset        (reset),
        .fetch_valid  (fetch_valid),
        .fetch_addr   (fetch_addr),
        .inst_valid   (inst_valid),
        .inst_data    (inst_data),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    // instruction encoders
    function automatic rv_pkg::word_t r_type(input logic [6:0] f7, input rv_pkg::reg_idx_t rs2,
            input rv_pkg::reg_idx_t rs1, input logic [2:0] f3, input rv_pkg::reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::op_reg};
    endfunction

    function automatic rv_pkg::word_t i_type(input logic [11:0] imm, input rv_pkg::reg_idx_t rs1,
            input logic [2:0] f3, input rv_pkg::reg_idx_t rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_pkg::word_t u_type(input logic [19:0] imm, input rv_pkg::reg_idx_t rd,
            input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic rv_pkg::word_t b_type(input logic [12:0] imm, input rv_pkg::reg_idx_t rs2,
            input rv_pkg::reg_idx_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::op_branch};
    endfunction

    function automatic rv_pkg::word_t j_type(input logic [20:0] imm, input rv_pkg::reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::op_jal};
    endfunction

    // integer ops as the isa defines them
    function automatic rv_pkg::word_t alu_model(input logic [2:0] f3, input logic alt,
            input rv_pkg::word_t a, input rv_pkg::word_t b);
        rv_pkg::word_t res;
        case (f3)
            3'd0: res = alt ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = {31'b0, $signed(a) < $signed(b)};
            3'd3: res = {31'b0, a < b};
            3'd4: res = a ^ b;
            3'd5: begin
                if (alt) res = $signed(a) >>> b[4:0];
                else res = a >> b[4:0];
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input rv_pkg::word_t a,
            input rv_pkg::word_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic show_mismatch(input string name, input rv_pkg::word_t exp,
            input rv_pkg::word_t act);
        errors++;
        $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
    endtask

    task automatic fail_check(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        restart = 1'b1;
        @(negedge clk);
        restart = 1'b0;
        while (reset) begin
            assert (!fetch_valid && !retire_valid)
                else fail_check("fetch or retire strobe raised while reset is held");
            @(negedge clk);
        end
    endtask

    // steps the shadow state by one instruction and compares the retire port
    task automatic check_retire(input rv_pkg::word_t inst);
        logic [6:0]        opcode;
        logic [2:0]        f3;
        rv_pkg::reg_idx_t  rd;
        rv_pkg::word_t     a;
        rv_pkg::word_t     b;
        rv_pkg::word_t     imm_i;
        rv_pkg::word_t     exp_wdata;
        rv_pkg::word_t     exp_next;
        logic              exp_we;
        logic              exp_ill;
        opcode    = inst[6:0];
        f3        = inst[14:12];
        rd        = inst[11:7];
        a         = ref_regs[inst[19:15]];
        b         = ref_regs[inst[24:20]];
        imm_i     = {{20{inst[31]}}, inst[31:20]};
        exp_next  = ref_pc + 4;
        exp_wdata = '0;
        exp_we    = 1'b1;
        exp_ill   = 1'b0;
        case (opcode)
            rv_pkg::op_reg:   exp_wdata = alu_model(f3, inst[30], a, b);
            rv_pkg::op_imm:   exp_wdata = alu_model(f3, inst[30] && f3 == 3'd5, a, imm_i);
            rv_pkg::op_lui:   exp_wdata = {inst[31:12], 12'b0};
            rv_pkg::op_auipc: exp_wdata = ref_pc + {inst[31:12], 12'b0};
            rv_pkg::op_jal: begin
                exp_wdata = ref_pc + 4;
                exp_next  = ref_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            rv_pkg::op_jalr: begin
                exp_wdata = ref_pc + 4;
                exp_next  = (a + imm_i) & ~32'd1;
            end
            rv_pkg::op_branch: begin
                exp_we = 1'b0;
                if (branch_model(f3, a, b))
                    exp_next = ref_pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            default: begin
                exp_we  = 1'b0;
                exp_ill = 1'b1;
            end
        endcase
        assert (retire.pc == ref_pc) else show_mismatch("retire.pc", ref_pc, retire.pc);
        assert (retire.illegal == exp_ill)
            else show_mismatch("retire.illegal", 32'(exp_ill), 32'(retire.illegal));
        assert (retire.we == exp_we) else show_mismatch("retire.we", 32'(exp_we), 32'(retire.we));
        if (exp_we) begin
            assert (retire.rd == rd) else show_mismatch("retire.rd", 32'(rd), 32'(retire.rd));
            assert (retire.wdata == exp_wdata)
                else show_mismatch("retire.wdata", exp_wdata, retire.wdata);
            if (rd != 5'd0) ref_regs[rd] = exp_wdata;
        end
        ref_pc = exp_next;
    endtask

    // loads prog_q, resets the core and serves fetches until the program falls off its end
    task automatic run_program(input string name);
        int            wait_left;
        int            req_idx;
        int            cycle;
        logic          prev_iv;
        logic          done;
        rv_pkg::word_t offset;
        rv_pkg::word_t end_addr;
        for (int i = 0; i < mem_words; i++) mem[i] = {i[24:0], 7'b0000011};
        foreach (prog_q[i]) mem[i] = prog_q[i];
        for (int i = 0; i < 32; i++) ref_regs[i] = '0;
        ref_pc    = reset_pc;
        end_addr  = reset_pc + 4 * prog_q.size();
        wait_left = 0;
        req_idx   = 0;
        cycle     = 0;
        done      = 1'b0;
        $display("running %s, %0d instructions", name, prog_q.size());
        apply_reset();
        while (!done) begin
            @(posedge clk);
            #1;
            prev_iv    = inst_valid;
            inst_valid = 1'b0;
            if (wait_left > 0) begin
                wait_left--;
                if (wait_left == 0) begin
                    inst_valid = 1'b1;
                    inst_data  = mem[req_idx];
                end
            end
            @(negedge clk);  // outputs settled
            cycle++;
            if (retire_valid) begin
                assert (prev_iv) else fail_check("retire without inst_valid in the cycle before");
                assert (fetch_valid) else fail_check("no next fetch in the retire cycle");
                check_retire(mem[req_idx]);
                done = (ref_pc == end_addr);
            end else begin
                assert (!prev_iv) else fail_check("no retire one cycle after inst_valid");
            end
            if (cycle == 1) begin
                assert (fetch_valid) else fail_check("first fetch missing after reset release");
            end else if (!retire_valid) begin
                assert (!fetch_valid)
                    else fail_check("fetch strobe raised while waiting for memory");
            end
            if (fetch_valid) begin
                assert (fetch_addr == ref_pc) else show_mismatch("fetch_addr", ref_pc, fetch_addr);
                offset = fetch_addr - reset_pc;
                if (offset >= 4 * mem_words || offset[1:0] != 2'b00) begin
                    fail_check("fetch address outside the program memory");
                    done = 1'b1;
                end else begin
                    req_idx   = int'(offset >> 2);
                    wait_left = 1 + int'($unsigned($random(seed)) % 3);  // 1 to 3 cycles
                end
            end
        end
        prog_q.delete();
    endtask

    task automatic arith_test();
        rv_pkg::word_t    r;
        rv_pkg::reg_idx_t rs1;
        rv_pkg::reg_idx_t rs2;
        rv_pkg::reg_idx_t rd;
        logic [2:0]       imm_f3 [6] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
        for (int i = 1; i <= 4; i++) begin  // random operands in x1..x4
            r = $random(seed);
            prog_q.push_back(u_type(r[31:12], 5'(i), rv_pkg::op_lui));
            prog_q.push_back(i_type(r[11:0], 5'(i), 3'd0, 5'(i), rv_pkg::op_imm));
        end
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 0 || f3 == 0 || f3 == 5) begin
                    r   = $random(seed);
                    rs1 = {3'b0, r[1:0]} + 5'd1;
                    rs2 = {3'b0, r[3:2]} + 5'd1;
                    rd  = {2'b0, r[6:4]} + 5'd5;
                    prog_q.push_back(r_type({1'b0, alt[0], 5'b0}, rs2, rs1, f3[2:0], rd));
                end
            end
        end
        foreach (imm_f3[k]) begin
            r   = $random(seed);
            rs1 = {3'b0, r[1:0]} + 5'd1;
            rd  = {2'b0, r[6:4]} + 5'd5;
            prog_q.push_back(i_type(r[31:20], rs1, imm_f3[k], rd, rv_pkg::op_imm));
        end
        r = $random(seed);
        prog_q.push_back(i_type({7'b0, r[24:20]}, 5'd1, 3'd1, 5'd13, rv_pkg::op_imm));
        prog_q.push_back(i_type({7'b0, r[14:10]}, 5'd2, 3'd5, 5'd14, rv_pkg::op_imm));
        prog_q.push_back(i_type({7'b0100000, r[9:5]}, 5'd3, 3'd5, 5'd15, rv_pkg::op_imm));
        run_program("arithmetic");
    endtask

    task automatic x0_test();
        prog_q.push_back(i_type(12'd123, 5'd0, 3'd0, 5'd0, rv_pkg::op_imm));
        prog_q.push_back(u_type(20'habcde, 5'd0, rv_pkg::op_lui));
        prog_q.push_back(r_type(7'd0, 5'd0, 5'd0, 3'd0, 5'd7));  // x0 read back
        prog_q.push_back(i_type(12'd9, 5'd0, 3'd6, 5'd8, rv_pkg::op_imm));
        run_program("x0 hardwired");
    endtask

    task automatic upper_imm_test();
        prog_q.push_back(u_type(20'h12345, 5'd1, rv_pkg::op_lui));
        prog_q.push_back(u_type(20'hfedcb, 5'd2, rv_pkg::op_lui));
        prog_q.push_back(u_type(20'h00001, 5'd3, rv_pkg::op_auipc));
        prog_q.push_back(u_type(20'hfffff, 5'd4, rv_pkg::op_auipc));
        run_program("lui and auipc");
    endtask

    task automatic control_flow_test();
        logic [2:0]       br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        rv_pkg::reg_idx_t pair_a [3] = '{5'd1, 5'd1, 5'd3};
        rv_pkg::reg_idx_t pair_b [3] = '{5'd2, 5'd3, 5'd1};
        prog_q.push_back(i_type(12'd5, 5'd0, 3'd0, 5'd1, rv_pkg::op_imm));
        prog_q.push_back(i_type(12'd5, 5'd0, 3'd0, 5'd2, rv_pkg::op_imm));
        prog_q.push_back(i_type(12'hffd, 5'd0, 3'd0, 5'd3, rv_pkg::op_imm));  // -3
        // equal, signed / unsigned split pairs give both outcomes per condition
        foreach (br_f3[c]) begin
            foreach (pair_a[p]) begin
                prog_q.push_back(b_type(13'd8, pair_b[p], pair_a[p], br_f3[c]));
                prog_q.push_back(i_type(12'd1, 5'd10, 3'd0, 5'd10, rv_pkg::op_imm));
            end
        end
        prog_q.push_back(j_type(21'd8, 5'd5));
        prog_q.push_back(i_type(12'd1, 5'd10, 3'd0, 5'd10, rv_pkg::op_imm));
        prog_q.push_back(u_type(20'h0, 5'd7, rv_pkg::op_auipc));
        prog_q.push_back(i_type(12'd13, 5'd7, 3'd0, 5'd6, rv_pkg::op_jalr));  // odd target
        prog_q.push_back(i_type(12'd1, 5'd10, 3'd0, 5'd10, rv_pkg::op_imm));
        run_program("branches and jumps");
    endtask

    task automatic illegal_op_test();
        prog_q.push_back(i_type(12'd7, 5'd0, 3'd0, 5'd1, rv_pkg::op_imm));
        prog_q.push_back(i_type(12'd0, 5'd1, 3'd2, 5'd2, 7'b0000011));  // load
        prog_q.push_back(i_type(12'd4, 5'd1, 3'd2, 5'd3, 7'b0100011));  // store
        prog_q.push_back(i_type(12'd1, 5'd2, 3'd0, 5'd3, rv_pkg::op_imm));
        run_program("illegal opcode");
    endtask

    initial begin
        seed       = 32'h8f80_39e2;
        errors     = 0;
        restart    = 1'b0;
        inst_valid = 1'b0;
        inst_data  = '0;
        arith_test();
        x0_test();
        upper_imm_test();
        control_flow_test();
        illegal_op_test();
        $display("tests done, %0d errors", errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Error: watchdog expired, the core stopped retiring instructions");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
